//--- hdl/rv32i_params.svh
// Sizes shared by the execute slice and its testbench
// RESQ_DEPTH also sets the producer's instruction credits after reset
`ifndef RV32I_PARAMS_SVH
`define RV32I_PARAMS_SVH

// Data path and register select widths
`define XLEN 32
`define REG_ADDR_W 5

// Result FIFO entries
`define RESQ_DEPTH 4

// Result credits the core holds after reset
`define RES_CREDITS 2

`endif

//--- hdl/rv32i_types_pkg.sv
// Encodings follow the RV32I base ISA
// Only LUI and the integer ALU groups are executed by the slice
package rv32i_types_pkg;

  // Base opcodes, bits [6:0] of the instruction word
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  // funct3 for the register-immediate group
  typedef enum logic [2:0] {
    ADDI  = 3'b000,
    SLLI  = 3'b001,
    SLTI  = 3'b010,
    SLTIU = 3'b011,
    XORI  = 3'b100,
    SRI   = 3'b101,
    ORI   = 3'b110,
    ANDI  = 3'b111
  } imm_funct3_t;

  // funct3 for the register-register group
  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } reg_funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } aluop_t;

  typedef enum logic [1:0] {
    RES_OK          = 2'd0,
    RES_UNSUPPORTED = 2'd1,
    RES_ILLEGAL     = 2'd2
  } res_status_t;

endpackage

//--- hdl/control_unit_if.sv
// Decoded control from the decoder to the ALU and the result FIFO
// instr is driven by the top level
`timescale 1ns/10ps
`include "rv32i_params.svh"

interface control_unit_if;
  import rv32i_types_pkg::*;

  logic [`XLEN-1:0] instr;
  opcode_t          instr_opcode;
  logic [`XLEN-1:0] imm;
  aluop_t           alu_op;
  logic             b_is_imm;
  logic             wen;
  res_status_t      status;

  modport control_unit (
    input  instr,
    output instr_opcode, imm, alu_op, b_is_imm, wen, status
  );

  modport alu (input alu_op, b_is_imm, imm);

  modport queue (input wen, status);

endinterface

//--- hdl/control_unit.sv
// Purely combinational decode within the accept cycle
// Only LUI and the integer ALU groups write a register
`timescale 1ns/10ps
`include "rv32i_params.svh"

module control_unit (
  input  logic [`XLEN-1:0]       instr_i,
  output logic [`REG_ADDR_W-1:0] rs1_o,
  output logic [`REG_ADDR_W-1:0] rs2_o,
  output logic [`REG_ADDR_W-1:0] rd_o,
  control_unit_if.control_unit   cu_if
);
  import rv32i_types_pkg::*;

  imm_funct3_t f3_imm;
  reg_funct3_t f3_reg;
  logic [6:0]  funct7;
  logic        is_imm;
  logic        is_reg;
  logic        is_shr;
  logic        is_sll;
  res_status_t status;

  // Register selects straight from the port word
  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign rd_o  = instr_i[11:7];

  assign cu_if.instr_opcode = opcode_t'(cu_if.instr[6:0]);
  assign f3_imm = imm_funct3_t'(cu_if.instr[14:12]);
  assign f3_reg = reg_funct3_t'(cu_if.instr[14:12]);
  assign funct7 = cu_if.instr[31:25];

  assign is_imm = (cu_if.instr_opcode == IMMED);
  assign is_reg = (cu_if.instr_opcode == REGREG);

  // U immediate for LUI, sign-extended I immediate otherwise
  assign cu_if.imm = (cu_if.instr_opcode == LUI) ? {cu_if.instr[31:12], 12'b0} :
                     {{(`XLEN-12){cu_if.instr[31]}}, cu_if.instr[31:20]};

  assign cu_if.b_is_imm = is_imm || (cu_if.instr_opcode == LUI);

  assign is_sll = (is_imm && f3_imm == SLLI) || (is_reg && f3_reg == SLL);
  assign is_shr = (is_imm && f3_imm == SRI) || (is_reg && f3_reg == SR);

  // Bit 30 separates SUB from ADD and SRA from SRL
  always_comb begin
    if (cu_if.instr_opcode == LUI)
      cu_if.alu_op = ALU_PASS_B;
    else if (is_sll)
      cu_if.alu_op = ALU_SLL;
    else if (is_shr)
      cu_if.alu_op = cu_if.instr[30] ? ALU_SRA : ALU_SRL;
    else if (is_reg && f3_reg == ADDSUB && cu_if.instr[30])
      cu_if.alu_op = ALU_SUB;
    else if ((is_imm && f3_imm == ANDI) || (is_reg && f3_reg == AND))
      cu_if.alu_op = ALU_AND;
    else if ((is_imm && f3_imm == ORI) || (is_reg && f3_reg == OR))
      cu_if.alu_op = ALU_OR;
    else if ((is_imm && f3_imm == XORI) || (is_reg && f3_reg == XOR))
      cu_if.alu_op = ALU_XOR;
    else if ((is_imm && f3_imm == SLTI) || (is_reg && f3_reg == SLT))
      cu_if.alu_op = ALU_SLT;
    else if ((is_imm && f3_imm == SLTIU) || (is_reg && f3_reg == SLTU))
      cu_if.alu_op = ALU_SLTU;
    else
      cu_if.alu_op = ALU_ADD;
  end

  always_comb begin
    case (cu_if.instr_opcode)
      LUI: status = RES_OK;
      IMMED: begin
        // Shift immediates only allow funct7 of 0x00 or 0x20
        if ((is_sll || is_shr) && funct7 != 7'h00 && funct7 != 7'h20)
          status = RES_ILLEGAL;
        else
          status = RES_OK;
      end
      // funct7 bit 0 marks the M extension
      REGREG: status = funct7[0] ? RES_ILLEGAL : RES_OK;
      AUIPC, JAL, JALR, BRANCH, LOAD, STORE, MISCMEM, SYSTEM:
        status = RES_UNSUPPORTED;
      default: status = RES_ILLEGAL;
    endcase
  end

  assign cu_if.status = status;
  assign cu_if.wen    = (status == RES_OK);

endmodule

//--- hdl/reg_file.sv
// x0 reads zero and ignores writes
// Reads are combinational and see the old value during a write
`timescale 1ns/10ps
`include "rv32i_params.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   we_i,
  input  logic                   wen_i,
  input  logic [`REG_ADDR_W-1:0] rs1_i,
  input  logic [`REG_ADDR_W-1:0] rs2_i,
  input  logic [`REG_ADDR_W-1:0] rd_i,
  input  logic [`XLEN-1:0]       wdata_i,
  output logic [`XLEN-1:0]       rdata1_o,
  output logic [`XLEN-1:0]       rdata2_o
);

  localparam int NREGS = 2 ** `REG_ADDR_W;

  logic [`XLEN-1:0] regs [NREGS];
  logic             wr_en;

  // Accepted instruction that the decoder lets write
  assign wr_en = we_i && wen_i && (rd_i != '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NREGS; i++)
        regs[i] <= '0;
    end else if (wr_en) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

endmodule

//--- hdl/alu.sv
// Integer ALU for the RV32I register and immediate groups
// Shift amounts come from the low 5 bits of operand B
`timescale 1ns/10ps
`include "rv32i_params.svh"

module alu (
  input  logic [`XLEN-1:0] rdata1_i,
  input  logic [`XLEN-1:0] rdata2_i,
  control_unit_if.alu      cu_if,
  output logic [`XLEN-1:0] result_o
);
  import rv32i_types_pkg::*;

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;

  assign op_a  = rdata1_i;
  assign op_b  = cu_if.b_is_imm ? cu_if.imm : rdata2_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (cu_if.alu_op)
      ALU_ADD:    result_o = op_a + op_b;
      ALU_SUB:    result_o = op_a - op_b;
      ALU_SLL:    result_o = op_a << shamt;
      ALU_SRL:    result_o = op_a >> shamt;
      ALU_SRA:    result_o = $unsigned($signed(op_a) >>> shamt);
      ALU_AND:    result_o = op_a & op_b;
      ALU_OR:     result_o = op_a | op_b;
      ALU_XOR:    result_o = op_a ^ op_b;
      ALU_SLT:    result_o = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result_o = {{(`XLEN-1){1'b0}}, op_a < op_b};
      // LUI value is already in the immediate
      ALU_PASS_B: result_o = op_b;
      default:    result_o = '0;
    endcase
  end

endmodule

//--- hdl/result_queue.sv
// Never full because the producer holds only RESQ_DEPTH credits
// Head record is shown combinationally in the cycle it pops
`timescale 1ns/10ps
`include "rv32i_params.svh"

module result_queue (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         push_i,
  input  logic [`REG_ADDR_W-1:0]       rd_i,
  input  logic [`XLEN-1:0]             value_i,
  control_unit_if.queue                cu_if,
  input  logic                         res_credit_i,
  output logic                         res_valid_o,
  output logic [`REG_ADDR_W-1:0]       res_rd_o,
  output logic [`XLEN-1:0]             res_value_o,
  output rv32i_types_pkg::res_status_t res_status_o,
  output logic                         instr_credit_o
);
  import rv32i_types_pkg::*;

  localparam int DEPTH  = `RESQ_DEPTH;
  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = $clog2(`RES_CREDITS + 1);

  logic [`REG_ADDR_W-1:0] rd_mem     [DEPTH];
  logic [`XLEN-1:0]       value_mem  [DEPTH];
  res_status_t            status_mem [DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] credits;
  logic              pop;

  assign pop = (count != '0) && (credits != '0);

  // Payload storage with rd and value zeroed for records that write nothing
  always_ff @(posedge clk) begin
    if (push_i) begin
      rd_mem[wr_ptr]     <= cu_if.wen ? rd_i : '0;
      value_mem[wr_ptr]  <= cu_if.wen ? value_i : '0;
      status_mem[wr_ptr] <= cu_if.status;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRED_W'(`RES_CREDITS);
    end else begin
      if (push_i)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Returned credit and pop in the same cycle cancel out
      case ({res_credit_i, pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  assign res_valid_o    = pop;
  assign instr_credit_o = pop;
  assign res_rd_o       = rd_mem[rd_ptr];
  assign res_value_o    = value_mem[rd_ptr];
  assign res_status_o   = status_mem[rd_ptr];

endmodule

//--- hdl/rv32i_exec_core.sv
// Producer starts with RESQ_DEPTH instruction credits, core with RES_CREDITS
// instr_i is only sampled in a cycle with instr_valid_i high
`timescale 1ns/10ps
`include "rv32i_params.svh"

module rv32i_exec_core (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         instr_valid_i,
  input  logic [`XLEN-1:0]             instr_i,
  output logic                         instr_credit_o,
  output logic                         res_valid_o,
  output logic [`REG_ADDR_W-1:0]       res_rd_o,
  output logic [`XLEN-1:0]             res_value_o,
  output rv32i_types_pkg::res_status_t res_status_o,
  input  logic                         res_credit_i
);

  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       rdata1;
  logic [`XLEN-1:0]       rdata2;
  logic [`XLEN-1:0]       alu_result;

  control_unit_if cu_if ();

  assign cu_if.instr = instr_i;

  control_unit u_control_unit (
    .instr_i (instr_i),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .rd_o    (rd),
    .cu_if   (cu_if)
  );

  // Write happens at the accept edge, qualified by the decoder
  reg_file u_reg_file (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .we_i     (instr_valid_i),
    .wen_i    (cu_if.wen),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rd_i     (rd),
    .wdata_i  (alu_result),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  alu u_alu (
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .cu_if    (cu_if),
    .result_o (alu_result)
  );

  result_queue u_result_queue (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .push_i         (instr_valid_i),
    .rd_i           (rd),
    .value_i        (alu_result),
    .cu_if          (cu_if),
    .res_credit_i   (res_credit_i),
    .res_valid_o    (res_valid_o),
    .res_rd_o       (res_rd_o),
    .res_value_o    (res_value_o),
    .res_status_o   (res_status_o),
    .instr_credit_o (instr_credit_o)
  );

endmodule

//--- sim/tb_rv32i_exec_core.sv
// Directed testbench for the execute slice with a shadow register model
// Outputs are sampled at the rising edge and inputs are driven at the falling edge
`timescale 1ns/10ps
`include "rv32i_params.svh"

module tb_rv32i_exec_core;

  localparam int TIMEOUT = 2000;

  logic                   clk;
  logic                   rst_n_i;
  logic                   instr_valid_i;
  logic [`XLEN-1:0]       instr_i;
  logic                   instr_credit_o;
  logic                   res_valid_o;
  logic [`REG_ADDR_W-1:0] res_rd_o;
  logic [`XLEN-1:0]       res_value_o;
  logic [1:0]             res_status_o;
  logic                   res_credit_i;

  // Shadow registers and expected records of {rd, status, value}
  logic [31:0] shadow [32];
  logic [38:0] exp_q [$];
  logic [38:0] exp_rec;
  logic [38:0] got_rec;
  logic [31:0] lfsr_state;
  int          icred;
  int          owed;
  int          gap_left;
  int          results_seen;
  int          errors;
  int          checks;
  int          err_start;
  logic        hold_credits;
  logic        random_gaps;
  logic        credit_next;
  string       test_name;

  rv32i_exec_core u_rv32i_exec_core (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .res_valid_o    (res_valid_o),
    .res_rd_o       (res_rd_o),
    .res_value_o    (res_value_o),
    .res_status_o   (res_status_o),
    .res_credit_i   (res_credit_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      if (lfsr_state[0])
        lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
      else
        lfsr_state = lfsr_state >> 1;
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'h37};
  endfunction

  // Reference model that queues the record the core must emit
  function automatic void model_step(input logic [31:0] w);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    logic [1:0]  st;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    rd = w[11:7];
    a  = shadow[w[19:15]];
    b  = (op == 7'h33) ? shadow[w[24:20]] : {{20{w[31]}}, w[31:20]};
    v  = '0;
    st = 2'd0;
    case (op)
      7'h37: v = {w[31:12], 12'h000};
      7'h13, 7'h33: begin
        if (op == 7'h33 && f7[0])
          st = 2'd2;
        else if (op == 7'h13 && (f3 == 3'd1 || f3 == 3'd5) && f7 != 7'h00 && f7 != 7'h20)
          st = 2'd2;
        else begin
          case (f3)
            3'd0: v = (op == 7'h33 && w[30]) ? a - b : a + b;
            3'd1: v = a << b[4:0];
            3'd2: v = {31'b0, $signed(a) < $signed(b)};
            3'd3: v = {31'b0, a < b};
            3'd4: v = a ^ b;
            3'd5: v = w[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: v = a | b;
            default: v = a & b;
          endcase
        end
      end
      7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h0f, 7'h73: st = 2'd1;
      default: st = 2'd2;
    endcase
    if (st != 2'd0) begin
      rd = '0;
      v  = '0;
    end else if (rd != 5'd0) begin
      shadow[rd] = v;
    end
    exp_q.push_back({rd, st, v});
  endfunction

  task automatic abort_run(input string what);
    $display("timeout in test %s: %s", test_name, what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic check_count(input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      $display("mismatch %s expected %0d actual %0d", test_name, expected, actual);
      errors++;
    end
  endtask

  // Waits for an instruction credit, then drives one valid cycle
  task automatic issue(input logic [31:0] w);
    int t;
    t = 0;
    while (icred == 0 && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (icred == 0) begin
      abort_run("no instruction credit came back");
    end else begin
      model_step(w);
      instr_i       = w;
      instr_valid_i = 1'b1;
      icred--;
      @(negedge clk);
      instr_valid_i = 1'b0;
    end
  endtask

  function automatic logic settled();
    return exp_q.size() == 0 && icred == `RESQ_DEPTH && owed == 0 && !credit_next;
  endfunction

  task automatic drain();
    int t;
    t = 0;
    while (!settled() && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!settled())
      abort_run("results or credits still outstanding");
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", test_name, errors - err_start);
  endtask

  // Result monitor and consumer credit policy
  always @(posedge clk) begin
    if (rst_n_i) begin
      checks++;
      assert (instr_credit_o == res_valid_o) else begin
        $display("instruction credit pulse not aligned with result in test %s", test_name);
        errors++;
      end
      if (instr_credit_o)
        icred++;
      if (res_valid_o) begin
        results_seen++;
        owed++;
        got_rec = {res_rd_o, res_status_o, res_value_o};
        if (exp_q.size() == 0) begin
          $display("result %h arrived with none expected in test %s", got_rec, test_name);
          errors++;
        end else begin
          exp_rec = exp_q.pop_front();
          checks++;
          assert (exp_rec == got_rec) else begin
            $display("mismatch %s expected %h actual %h", test_name, exp_rec, got_rec);
            errors++;
          end
        end
      end
      credit_next = 1'b0;
      if (!hold_credits && owed > 0) begin
        if (gap_left > 0) begin
          gap_left--;
        end else begin
          credit_next = 1'b1;
          owed--;
          gap_left = random_gaps ? int'(lfsr_bits(2)) : 0;
        end
      end
    end
  end

  always @(negedge clk)
    res_credit_i = credit_next;

  task automatic test_reset();
    start_test("reset");
    for (int n = 0; n < 20; n++) begin
      @(negedge clk);
      checks++;
      assert (!res_valid_o && !instr_credit_o) else begin
        $display("result valid or credit pulse raised while idle after reset");
        errors++;
      end
    end
    check_count(`RESQ_DEPTH, icred);
    end_test();
  endtask

  task automatic test_immediate();
    start_test("immediate");
    issue(enc_lui(5'd1, 20'h80001));
    issue(enc_i(3'd0, 5'd2, 5'd0, 12'hff9));
    issue(enc_i(3'd2, 5'd3, 5'd2, 12'h001));
    issue(enc_i(3'd3, 5'd4, 5'd2, 12'h001));
    issue(enc_i(3'd4, 5'd5, 5'd1, 12'h7ff));
    issue(enc_i(3'd6, 5'd6, 5'd2, 12'h0f0));
    issue(enc_i(3'd7, 5'd7, 5'd1, 12'hfff));
    issue(enc_i(3'd1, 5'd8, 5'd2, 12'h004));
    issue(enc_i(3'd5, 5'd9, 5'd1, 12'h003));
    issue(enc_i(3'd5, 5'd10, 5'd1, 12'h403));
    // Read every result back through ADD with x0
    for (int r = 1; r <= 10; r++)
      issue(enc_r(7'h00, 3'd0, 5'd11, 5'(r), 5'd0));
    drain();
    end_test();
  endtask

  task automatic test_regreg();
    start_test("regreg");
    issue(enc_i(3'd0, 5'd1, 5'd0, 12'd100));
    issue(enc_i(3'd0, 5'd2, 5'd0, 12'hffd));
    issue(enc_i(3'd0, 5'd6, 5'd0, 12'd2));
    issue(enc_r(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
    issue(enc_r(7'h20, 3'd0, 5'd4, 5'd2, 5'd3));
    issue(enc_r(7'h20, 3'd5, 5'd5, 5'd4, 5'd6));
    issue(enc_r(7'h00, 3'd5, 5'd7, 5'd5, 5'd6));
    issue(enc_r(7'h00, 3'd1, 5'd8, 5'd7, 5'd6));
    issue(enc_r(7'h00, 3'd2, 5'd9, 5'd2, 5'd1));
    issue(enc_r(7'h00, 3'd3, 5'd10, 5'd2, 5'd1));
    issue(enc_r(7'h00, 3'd4, 5'd11, 5'd8, 5'd2));
    issue(enc_r(7'h00, 3'd6, 5'd12, 5'd11, 5'd1));
    issue(enc_r(7'h00, 3'd7, 5'd13, 5'd12, 5'd2));
    drain();
    end_test();
  endtask

  task automatic test_status();
    start_test("status");
    issue(32'h0000_2083);
    issue(32'h0020_8463);
    issue(32'h0000_0073);
    issue(enc_r(7'h01, 3'd0, 5'd1, 5'd2, 5'd3));
    issue(32'h0000_00ff);
    issue(enc_i(3'd0, 5'd0, 5'd1, 12'd7));
    // Targets above must be unchanged
    issue(enc_r(7'h00, 3'd0, 5'd16, 5'd0, 5'd0));
    issue(enc_r(7'h00, 3'd0, 5'd17, 5'd1, 5'd0));
    drain();
    end_test();
  endtask

  task automatic test_backpressure();
    int base;
    start_test("backpressure");
    base = results_seen;
    hold_credits = 1'b1;
    for (int n = 1; n <= `RESQ_DEPTH; n++)
      issue(enc_i(3'd0, 5'(n + 20), 5'(n), 12'(n)));
    repeat (20) @(negedge clk);
    check_count(`RES_CREDITS, results_seen - base);
    check_count(`RES_CREDITS, icred);
    hold_credits = 1'b0;
    drain();
    check_count(`RESQ_DEPTH, results_seen - base);
    check_count(`RESQ_DEPTH, icred);
    end_test();
  endtask

  task automatic test_random();
    logic [1:0]  kind;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [6:0]  f7;
    start_test("random");
    random_gaps = 1'b1;
    for (int n = 0; n < 200; n++) begin
      kind = 2'(lfsr_bits(2));
      f3   = 3'(lfsr_bits(3));
      rd   = 5'(lfsr_bits(5));
      rs1  = 5'(lfsr_bits(5));
      rs2  = 5'(lfsr_bits(5));
      imm  = 12'(lfsr_bits(12));
      f7   = (f3 == 3'd5 && lfsr_bits(1) == 32'd1) ? 7'h20 : 7'h00;
      if (kind == 2'd0) begin
        issue(enc_lui(rd, {imm, rs1, f3}));
      end else if (kind == 2'd1) begin
        if (f3 == 3'd1 || f3 == 3'd5)
          imm[11:5] = f7;
        issue(enc_i(f3, rd, rs1, imm));
      end else begin
        if (f3 == 3'd0 && lfsr_bits(1) == 32'd1)
          f7 = 7'h20;
        issue(enc_r(f7, f3, rd, rs1, rs2));
      end
    end
    drain();
    random_gaps = 1'b0;
    end_test();
  endtask

  initial begin
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    res_credit_i  = 1'b0;
    credit_next   = 1'b0;
    hold_credits  = 1'b0;
    random_gaps   = 1'b0;
    lfsr_state    = 32'h5842;
    icred         = `RESQ_DEPTH;
    owed          = 0;
    gap_left      = 0;
    results_seen  = 0;
    errors        = 0;
    checks        = 0;
    test_name     = "init";
    for (int r = 0; r < 32; r++)
      shadow[r] = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    test_reset();
    test_immediate();
    test_regreg();
    test_status();
    test_backpressure();
    test_random();
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+hdl
hdl/rv32i_types_pkg.sv
hdl/control_unit_if.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/result_queue.sv
hdl/rv32i_exec_core.sv
sim/tb_rv32i_exec_core.sv

//--- Bender.yml
package:
  name: rv32i_exec_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv32i_types_pkg.sv
      - hdl/control_unit_if.sv
      - hdl/control_unit.sv
      - hdl/reg_file.sv
      - hdl/alu.sv
      - hdl/result_queue.sv
      - hdl/rv32i_exec_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/tb_rv32i_exec_core.sv
